// File: tb.f
+incdir+verification
logic/rv_pkg.sv
logic/inst_decode.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/load_store_unit.sv
logic/core_top.sv
verification/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

FILELIST := tb.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
HDRS     := verification/rv_ref_model.svh
BIN      := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) | tee /dev/stderr | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

localparam logic [31:0] WIN_BASE = 32'h0000_0100; // 16-byte data window

logic [31:0] m_regs [32];
logic [7:0]  m_mem [16];
logic [31:0] m_pc;
logic        m_halted;
logic [31:0] rnd_state;
int          prog_len;
logic [31:0] inv_pc;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    rnd_state = xorshift32(rnd_state);
    return rnd_state;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

function automatic void emit(input logic [31:0] word);
    rom[prog_len] = word;
    prog_len++;
endfunction

// Byte offset inside the window with halves kept inside one word
function automatic logic [11:0] mem_off(input logic [2:0] f3, input logic [31:0] r);
    case (f3[1:0])
        2'b00:   return 12'(r[27:24]);
        2'b01:   return 12'(4 * r[27:26] + r[25:24] % 3);
        default: return 12'(4 * r[27:26]);
    endcase
endfunction

function automatic void gen_program(input bit with_invalid);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [6:0]  f7;
    logic [11:0] imm;
    for (int i = 0; i < ROM_WORDS; i++)
        rom[i] = EBREAK_INST;
    prog_len = 0;
    inv_pc   = '1;
    emit(enc_i(WIN_BASE[11:0], 5'd0, 3'b000, 5'd31, OP_IMM)); // x31 holds the window base
    for (int i = 1; i < 31; i++) begin
        r = next_rand();
        emit({r[31:12], 5'(i), LUI});
        emit(enc_i(r[11:0], 5'(i), 3'b000, 5'(i), OP_IMM));
    end
    for (int w = 0; w < 4; w++)
        emit(enc_s(12'(4 * w), 5'(w + 1), 5'd31, 3'b010));
    emit({20'h80000, 5'd5, LUI});
    emit(enc_i(12'hfff, 5'd0, 3'b000, 5'd6, OP_IMM));
    emit(enc_i(12'h000, 5'd0, 3'b000, 5'd7, OP_IMM));
    emit(enc_r(F7_MULDIV, 5'd6, 5'd5, 3'b100, 5'd8));  // Overflow DIV
    emit(enc_r(F7_MULDIV, 5'd6, 5'd5, 3'b110, 5'd9));  // Overflow REM
    emit(enc_r(F7_MULDIV, 5'd7, 5'd1, 3'b100, 5'd10)); // Divide by zero
    emit(enc_r(F7_MULDIV, 5'd7, 5'd1, 3'b101, 5'd11));
    emit(enc_r(F7_MULDIV, 5'd7, 5'd1, 3'b110, 5'd12));
    emit(enc_r(F7_MULDIV, 5'd7, 5'd1, 3'b111, 5'd13));
    emit(enc_r(F7_BASE, 5'd2, 5'd1, 3'b000, 5'd0));    // Write to x0
    emit(enc_r(F7_BASE, 5'd0, 5'd0, 3'b000, 5'd14));
    for (int n = 0; n < 150; n++) begin
        if (with_invalid && n == 75) begin
            emit(enc_i(12'h000, 5'd0, 3'b000, 5'd0, OP_IMM));
            emit(enc_i(12'h000, 5'd0, 3'b000, 5'd0, OP_IMM));
            inv_pc = 32'(prog_len * 4);
            emit(32'hffff_ffff);
        end
        r  = next_rand();
        rd = 5'(r[7:0] % 31);
        f3 = r[20:18];
        case (r[23:21])
            3'd0, 3'd1: begin
                f7 = (r[24] && (f3 == 3'b000 || f3 == 3'b101)) ? F7_ALT : F7_BASE;
                emit(enc_r(f7, r[17:13], r[12:8], f3, rd));
            end
            3'd2: begin
                if (f3 == 3'b010 || f3 == 3'b011)
                    f3 = {2'b00, f3[0]}; // No MULHSU or MULHU
                emit(enc_r(F7_MULDIV, r[17:13], r[12:8], f3, rd));
            end
            3'd3: begin
                if (f3 == 3'b001)
                    imm = {7'd0, r[28:24]};
                else if (f3 == 3'b101)
                    imm = {r[29] ? F7_ALT : F7_BASE, r[28:24]};
                else
                    imm = r[31:20];
                emit(enc_i(imm, r[12:8], f3, rd, OP_IMM));
            end
            3'd4: begin
                f3 = 3'(r[20:18] % 3);
                emit(enc_s(mem_off(f3, r), r[17:13], 5'd31, f3));
            end
            3'd5: begin
                if (f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111)
                    f3 = {f3[2], 1'b0, f3[0]};
                emit(enc_i(mem_off(f3, r), 5'd31, f3, 5'(r[7:0] % 30 + 1), LOAD));
            end
            3'd6: begin
                if (f3 == 3'b010 || f3 == 3'b011)
                    f3 = {1'b1, 1'b0, f3[0]};
                emit(enc_b(r[24] ? 13'd12 : 13'd8, r[17:13], r[12:8], f3));
            end
            default: begin
                case (r[25:24])
                    2'd0:    emit(enc_j(21'd8, rd));
                    2'd1:    emit(enc_i(12'(prog_len * 4 + 8), 5'd0, 3'b000, rd, JALR));
                    2'd2:    emit({r[31:12], rd, AUIPC});
                    default: emit({r[31:12], rd, LUI});
                endcase
            end
        endcase
    end
    emit(EBREAK_INST);
endfunction

`endif

// File: verification/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb import rv_pkg::*; ;

    localparam int ROM_WORDS    = 512;
    localparam int ROM_AW       = 9;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int HALT_WAIT    = 10;
    localparam longint WATCHDOG_NS =
        2 * (ROM_WORDS * 4 + RESET_CYCLES + HALT_WAIT + 4) * CLK_PERIOD; // Two runs

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] rom [ROM_WORDS];
    logic [31:0] inst;
    logic [31:0] inst_addr;
    logic        commit_valid;
    commit_t     commit;
    logic        halted;
    logic        exp_we;
    logic [4:0]  exp_rd;
    logic [31:0] exp_wdata;

    `include "rv_ref_model.svh"

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] muldiv_ref(input logic [2:0] f3, input logic [31:0] a,
                                               input logic [31:0] b);
        longint prod;
        int     sa;
        int     sb;
        logic   ovf;
        prod = longint'($signed(a)) * longint'($signed(b));
        sa   = a;
        sb   = b;
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (f3)
            3'b000:  return prod[31:0];
            3'b001:  return prod[63:32];
            3'b100:  return (b == 0) ? 32'hffff_ffff : (ovf ? 32'h8000_0000 : 32'(sa / sb));
            3'b101:  return (b == 0) ? 32'hffff_ffff : a / b;
            3'b110:  return (b == 0) ? a : (ovf ? 32'd0 : 32'(sa % sb));
            3'b111:  return (b == 0) ? a : a % b;
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Executes one instruction on the model and returns the expected commit fields
    function automatic void model_step(input logic [31:0] iw, output logic we,
                                       output logic [4:0] rd, output logic [31:0] wdata);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] addr;
        logic [31:0] npc;
        logic [2:0]  f3;
        int          o;
        a     = m_regs[iw[19:15]];
        b     = m_regs[iw[24:20]];
        f3    = iw[14:12];
        imm_i = {{20{iw[31]}}, iw[31:20]};
        imm_s = {{20{iw[31]}}, iw[31:25], iw[11:7]};
        imm_b = {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
        imm_j = {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};
        rd    = iw[11:7];
        we    = 1'b1;
        wdata = 32'd0;
        npc   = m_pc + 32'd4;
        addr  = a + ((iw[6:0] == STORE) ? imm_s : imm_i);
        o     = int'(addr[3:0]);
        case (iw[6:0])
            OP:     wdata = (iw[31:25] == F7_MULDIV) ? muldiv_ref(f3, a, b)
                                                     : alu_ref(f3, iw[30], a, b);
            OP_IMM: wdata = alu_ref(f3, (f3 == 3'b101) && iw[30], a, imm_i);
            LUI:    wdata = {iw[31:12], 12'd0};
            AUIPC:  wdata = m_pc + {iw[31:12], 12'd0};
            LOAD: begin
                case (f3)
                    3'b000:  wdata = {{24{m_mem[o][7]}}, m_mem[o]};
                    3'b100:  wdata = {24'd0, m_mem[o]};
                    3'b001:  wdata = {{16{m_mem[o+1][7]}}, m_mem[o+1], m_mem[o]};
                    3'b101:  wdata = {16'd0, m_mem[o+1], m_mem[o]};
                    default: wdata = {m_mem[o+3], m_mem[o+2], m_mem[o+1], m_mem[o]};
                endcase
            end
            STORE: begin
                we = 1'b0;
                m_mem[o] = b[7:0];
                if (f3 != 3'b000)
                    m_mem[o+1] = b[15:8];
                if (f3 == 3'b010) begin
                    m_mem[o+2] = b[23:16];
                    m_mem[o+3] = b[31:24];
                end
            end
            BRANCH: begin
                we = 1'b0;
                if (branch_ref(f3, a, b))
                    npc = m_pc + imm_b;
            end
            JAL: begin
                wdata = m_pc + 32'd4;
                npc   = m_pc + imm_j;
            end
            JALR: begin
                wdata = m_pc + 32'd4;
                npc   = (a + imm_i) & 32'hffff_fffe;
            end
            default: begin // EBREAK and anything unknown halt in place
                we       = 1'b0;
                npc      = m_pc;
                m_halted = 1'b1;
            end
        endcase
        if (we && rd != 5'd0)
            m_regs[rd] = wdata;
        m_pc = npc;
    endfunction

    assign inst = rom[inst_addr[ROM_AW+1:2]];

    core_top #(
        .DMEM_WORDS (256),
        .RESET_PC   (32'h0000_0000)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst         (inst),
        .inst_addr    (inst_addr),
        .commit_valid (commit_valid),
        .commit       (commit),
        .halted       (halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Commit fields are stable mid-cycle
    always @(negedge clk) begin
        assert (rst_n || !commit_valid) else begin
            $display("The core committed an instruction during reset");
            $display("TEST FAILED");
            $fatal(1);
        end
        if (rst_n && commit_valid) begin
            assert (!m_halted) else begin
                $display("The core committed an instruction after it should have halted");
                $display("TEST FAILED");
                $fatal(1);
            end
            check_field("commit.pc", commit.pc, m_pc);
            model_step(rom[m_pc[ROM_AW+1:2]], exp_we, exp_rd, exp_wdata);
            check_field("commit.we", 32'(commit.we), 32'(exp_we));
            if (exp_we) begin
                check_field("commit.rd", 32'(commit.rd), 32'(exp_rd));
                check_field("commit.wdata", commit.wdata, exp_wdata);
            end
        end
    end

    task automatic run_program(input bit with_invalid);
        gen_program(with_invalid);
        for (int i = 0; i < 32; i++)
            m_regs[i] = 32'd0;
        for (int i = 0; i < 16; i++)
            m_mem[i] = 8'd0;
        m_pc     = 32'd0;
        m_halted = 1'b0;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        while (!halted)
            @(posedge clk);
        repeat (HALT_WAIT) @(posedge clk);
        assert (halted && m_halted) else begin
            $display("The core and the model do not agree on the halt");
            $display("TEST FAILED");
            $fatal(1);
        end
        for (int i = 1; i < 32; i++)
            check_field($sformatf("x%0d", i), UUT.u_regs.regs[i], m_regs[i]);
        if (with_invalid)
            check_field("inst_addr", inst_addr, inv_pc);
    endtask

    initial begin
        rst_n     = 1'b0;
        rnd_state = 32'ha484;
        run_program(1'b0);
        run_program(1'b1); // Invalid word mid-program
        $display("TEST OK");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, the core never halted");
        $display("TEST FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: logic/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top import rv_pkg::*; #(
    parameter int          DMEM_WORDS = 256,
    parameter logic [31:0] RESET_PC   = 32'h0000_0000
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [31:0] inst,
    output logic      [31:0] inst_addr,
    output logic             commit_valid,
    output commit_t          commit,
    output logic             halted
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_HALT
    } state_e;

    state_e      state;
    logic [31:0] pc;
    logic        run;
    dec_inst_t   dec;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] result;
    logic [31:0] next_pc;
    logic [31:0] mem_addr;
    logic [31:0] store_data;
    logic [31:0] mem_data;
    logic        rf_we;
    opcode_e     lsu_opcode;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            pc    <= RESET_PC;
        end else begin
            case (state)
                ST_IDLE: state <= ST_RUN;
                ST_RUN: begin
                    pc <= next_pc;
                    if (dec.is_ebreak || dec.inst_invalid)
                        state <= ST_HALT;
                end
                default: state <= ST_HALT; // Stays halted
            endcase
        end
    end

    assign run       = (state == ST_RUN);
    assign halted    = (state == ST_HALT);
    assign inst_addr = pc;

    // No writes outside the run state
    assign rf_we      = run && dec.reg_write_en;
    assign lsu_opcode = run ? dec.opcode : SYSTEM;

    inst_decode u_decode (
        .inst (inst),
        .dec  (dec)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (dec.rs1_addr),
        .rs2_addr (dec.rs2_addr),
        .rd_addr  (dec.rd),
        .we       (rf_we),
        .wdata    (result),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_unit u_exec (
        .dec        (dec),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .pc         (pc),
        .mem_data   (mem_data),
        .result     (result),
        .next_pc    (next_pc),
        .mem_addr   (mem_addr),
        .store_data (store_data)
    );

    load_store_unit #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_lsu (
        .clk        (clk),
        .mem_addr   (mem_addr),
        .store_data (store_data),
        .opcode     (lsu_opcode),
        .funct3     (dec.funct3),
        .mem_data   (mem_data)
    );

    assign commit_valid = run;
    assign commit.pc    = pc;
    assign commit.rd    = dec.rd;
    assign commit.we    = rf_we;
    assign commit.wdata = result;

endmodule

`default_nettype wire

// File: logic/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import rv_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  wire logic        clk,
    input  wire logic [31:0] mem_addr,
    input  wire logic [31:0] store_data,
    input  wire opcode_e      opcode,
    input  wire logic [2:0]  funct3,
    output logic      [31:0] mem_data
);

    localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    logic [31:0]      mem [DMEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic [1:0]       byte_off;
    logic [3:0]       lane_mask;
    logic [3:0]       lane_we;
    logic [31:0]      wr_word;
    logic [31:0]      rd_word;

    // Word index wraps at the memory depth
    assign word_idx = IDX_W'(mem_addr[31:2] % 30'(DMEM_WORDS));
    assign byte_off = mem_addr[1:0];

    assign rd_word  = mem[word_idx];
    assign mem_data = rd_word >> {byte_off, 3'b000}; // Addressed byte lands in [7:0]

    always_comb begin
        case (mem_width_e'(funct3))
            BYTE:    lane_mask = 4'b0001 << byte_off;
            HALF:    lane_mask = 4'b0011 << byte_off;
            WORD:    lane_mask = 4'b1111;
            default: lane_mask = 4'b0000;
        endcase
    end

    assign lane_we = (opcode == STORE) ? lane_mask : 4'b0000;
    assign wr_word = store_data << {byte_off, 3'b000};

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (lane_we[i])
                mem[word_idx][8*i +: 8] <= wr_word[8*i +: 8];
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit import rv_pkg::*; (
    input  wire dec_inst_t    dec,
    input  wire logic [31:0] rs1_data,
    input  wire logic [31:0] rs2_data,
    input  wire logic [31:0] pc,
    input  wire logic [31:0] mem_data,
    output logic      [31:0] result,
    output logic      [31:0] next_pc,
    output logic      [31:0] mem_addr,
    output logic      [31:0] store_data
);

    logic [31:0]        alu_a;
    logic [31:0]        alu_b;
    logic [31:0]        sum;
    logic [4:0]         shamt;
    logic [31:0]        alu_out;
    logic [31:0]        muldiv_out;
    logic [31:0]        load_ext;
    logic [31:0]        pc_plus4;
    logic signed [63:0] mul_full;
    logic               div_zero;
    logic               div_ovf;
    logic [31:0]        div_b;
    logic [31:0]        quot_s;
    logic [31:0]        rem_s;
    logic [31:0]        quot_u;
    logic [31:0]        rem_u;
    logic               taken;

    always_comb begin
        case (dec.opcode)
            AUIPC, JAL: alu_a = pc;
            LUI:        alu_a = 32'd0;
            default:    alu_a = rs1_data;
        endcase
    end

    assign alu_b = (dec.opcode == OP || dec.opcode == BRANCH) ? rs2_data : dec.imm;
    assign sum   = alu_a + alu_b;
    assign shamt = alu_b[4:0]; // imm[4:0] for the immediate shifts

    always_comb begin
        case (dec.funct3)
            3'b000:  alu_out = (dec.opcode == OP && dec.funct7 == F7_ALT) ? alu_a - alu_b : sum;
            3'b001:  alu_out = alu_a << shamt;
            3'b010:  alu_out = {31'd0, $signed(alu_a) < $signed(alu_b)};
            3'b011:  alu_out = {31'd0, alu_a < alu_b};
            3'b100:  alu_out = alu_a ^ alu_b;
            3'b101:  alu_out = (dec.funct7 == F7_ALT) ? 32'($signed(alu_a) >>> shamt)
                                                      : alu_a >> shamt;
            3'b110:  alu_out = alu_a | alu_b;
            default: alu_out = alu_a & alu_b;
        endcase
    end

    assign mul_full = $signed(alu_a) * $signed(alu_b);

    // Divider sees a safe divisor and the special cases are muxed in below
    assign div_zero = (alu_b == 32'd0);
    assign div_ovf  = (alu_a == 32'h8000_0000) && (alu_b == 32'hffff_ffff);
    assign div_b    = (div_zero || div_ovf) ? 32'd1 : alu_b;
    assign quot_s   = 32'($signed(alu_a) / $signed(div_b));
    assign rem_s    = 32'($signed(alu_a) % $signed(div_b));
    assign quot_u   = alu_a / div_b;
    assign rem_u    = alu_a % div_b;

    always_comb begin
        case (dec.funct3)
            3'b000:  muldiv_out = mul_full[31:0];
            3'b001:  muldiv_out = mul_full[63:32];
            3'b100:  muldiv_out = div_zero ? 32'hffff_ffff : (div_ovf ? 32'h8000_0000 : quot_s);
            3'b101:  muldiv_out = div_zero ? 32'hffff_ffff : quot_u;
            3'b110:  muldiv_out = div_zero ? alu_a : (div_ovf ? 32'd0 : rem_s);
            3'b111:  muldiv_out = div_zero ? alu_a : rem_u;
            default: muldiv_out = 32'd0;
        endcase
    end

    always_comb begin
        case (mem_width_e'(dec.funct3))
            BYTE:    load_ext = {{24{mem_data[7]}}, mem_data[7:0]};
            HALF:    load_ext = {{16{mem_data[15]}}, mem_data[15:0]};
            BYTE_U:  load_ext = {24'd0, mem_data[7:0]};
            HALF_U:  load_ext = {16'd0, mem_data[15:0]};
            default: load_ext = mem_data;
        endcase
    end

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (dec.opcode)
            OP:         result = (dec.funct7 == F7_MULDIV) ? muldiv_out : alu_out;
            OP_IMM:     result = alu_out;
            LUI, AUIPC: result = sum;
            LOAD:       result = load_ext;
            JAL, JALR:  result = pc_plus4; // Link
            default:    result = 32'd0;
        endcase
    end

    assign mem_addr   = rs1_data + dec.imm;
    assign store_data = rs2_data;

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
            3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
            3'b110:  taken = rs1_data < rs2_data;
            default: taken = rs1_data >= rs2_data;
        endcase
    end

    always_comb begin
        if (dec.is_ebreak || dec.inst_invalid)
            next_pc = pc; // Core halts here
        else if (dec.opcode == JAL)
            next_pc = sum;
        else if (dec.opcode == JALR)
            next_pc = {mem_addr[31:1], 1'b0};
        else if (dec.opcode == BRANCH && taken)
            next_pc = pc + dec.imm;
        else
            next_pc = pc_plus4;
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [4:0]  rs1_addr,
    input  wire logic [4:0]  rs2_addr,
    input  wire logic [4:0]  rd_addr,
    input  wire logic        we,
    input  wire logic [31:0] wdata,
    output logic      [31:0] rs1_data,
    output logic      [31:0] rs2_data
);

    logic [31:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != 5'd0) begin
            regs[rd_addr] <= wdata;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: logic/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode import rv_pkg::*; (
    input  wire logic [31:0] inst,
    output dec_inst_t        dec
);

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        op_ok;

    assign f3 = inst[14:12];
    assign f7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // R-type funct3/funct7 pairs, MULHSU and MULHU left out
    assign op_ok = (f7 == F7_BASE)
                || (f7 == F7_ALT && (f3 == 3'b000 || f3 == 3'b101))
                || (f7 == F7_MULDIV && f3 != 3'b010 && f3 != 3'b011);

    always_comb begin
        dec              = '0;
        dec.opcode       = opcode_e'(inst[6:0]);
        dec.funct3       = f3;
        dec.funct7       = f7;
        dec.rd           = inst[11:7];
        dec.rs1_addr     = inst[19:15];
        dec.rs2_addr     = inst[24:20];
        case (inst[6:0])
            OP: begin
                dec.reg_write_en = 1'b1;
                dec.inst_invalid = !op_ok;
            end
            OP_IMM: begin
                dec.imm          = imm_i;
                dec.reg_write_en = 1'b1;
                if (f3 == 3'b001)
                    dec.inst_invalid = (f7 != F7_BASE);
                else if (f3 == 3'b101)
                    dec.inst_invalid = (f7 != F7_BASE) && (f7 != F7_ALT);
            end
            LOAD: begin
                dec.imm          = imm_i;
                dec.reg_write_en = 1'b1;
                dec.inst_invalid = (f3 == 3'b011) || (f3 == 3'b110) || (f3 == 3'b111);
            end
            STORE: begin
                dec.imm          = imm_s;
                dec.inst_invalid = f3[2] || (f3 == 3'b011);
            end
            BRANCH: begin
                dec.imm          = imm_b;
                dec.inst_invalid = (f3 == 3'b010) || (f3 == 3'b011);
            end
            JAL: begin
                dec.imm          = imm_j;
                dec.reg_write_en = 1'b1;
            end
            JALR: begin
                dec.imm          = imm_i;
                dec.reg_write_en = 1'b1;
                dec.inst_invalid = (f3 != 3'b000);
            end
            LUI, AUIPC: begin
                dec.imm          = imm_u;
                dec.reg_write_en = 1'b1;
            end
            SYSTEM: begin
                dec.is_ebreak    = (inst == EBREAK_INST);
                dec.inst_invalid = (inst != EBREAK_INST); // No CSRs or ECALL
            end
            default: dec.inst_invalid = 1'b1;
        endcase
        if (dec.inst_invalid)
            dec.reg_write_en = 1'b0;
    end

endmodule

`default_nettype wire

// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        BYTE   = 3'b000,
        HALF   = 3'b001,
        WORD   = 3'b010,
        BYTE_U = 3'b100,
        HALF_U = 3'b101
    } mem_width_e;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // SUB, SRA, SRAI
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam logic [31:0] EBREAK_INST = 32'h0010_0073;

    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [4:0]  rd;
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [31:0] imm;          // Sign-extended per format
        logic        reg_write_en;
        logic        is_ebreak;
        logic        inst_invalid;
    } dec_inst_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        we;
        logic [31:0] wdata;
    } commit_t;

endpackage

`default_nettype wire
